/* logic/axi4_lite_if.sv */
interface axi4_lite_if;

  import wb_pkg::*;

  logic [AXI_ADDR_W-1:0]   awaddr;
  logic                    awvalid;
  logic                    awready;
  logic [AXI_DATA_W-1:0]   wdata;
  logic [AXI_DATA_W/8-1:0] wstrb;
  logic                    wvalid;
  logic                    wready;
  logic                    bvalid;
  logic                    bready;
  logic [1:0]              bresp;
  logic [AXI_ADDR_W-1:0]   araddr;
  logic                    arvalid;
  logic                    arready;
  logic [AXI_DATA_W-1:0]   rdata;
  logic                    rvalid;
  logic                    rready;
  logic [1:0]              rresp;

  modport master (
    output awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
    input  awready, wready, bvalid, bresp, arready, rdata, rvalid, rresp
  );

  modport slave (
    input  awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
    output awready, wready, bvalid, bresp, arready, rdata, rvalid, rresp
  );

endinterface

/* logic/wb_coef_bank.sv */
module wb_coef_bank (
  input                             clk_i,
  input                             rst_i,
  wb_ctrl_if.slave                  ctrl_i,
  input        [wb_pkg::COEF_W-1:0] auto_gain_r_i,
  input        [wb_pkg::COEF_W-1:0] auto_gain_b_i,
  input                             cal_done_i,
  output logic [wb_pkg::COEF_W-1:0] gain_r_o,
  output logic [wb_pkg::COEF_W-1:0] gain_g_o,
  output logic [wb_pkg::COEF_W-1:0] gain_b_o
);

import wb_pkg::*;

logic [COEF_W-1:0] auto_r;
logic [COEF_W-1:0] auto_b;
logic [COEF_W-1:0] man_r;
logic [COEF_W-1:0] man_g;
logic [COEF_W-1:0] man_b;
logic              man_lock_d1;
logic              lock_rise;

assign lock_rise = ctrl_i.man_lock && !man_lock_d1;

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    begin
      auto_r      <= COEF_ONE;
      auto_b      <= COEF_ONE;
      man_r       <= COEF_ONE;
      man_g       <= COEF_ONE;
      man_b       <= COEF_ONE;
      man_lock_d1 <= 1'b0;
    end
  else
    begin
      man_lock_d1 <= ctrl_i.man_lock;
      if( cal_done_i )
        begin
          auto_r <= auto_gain_r_i;
          auto_b <= auto_gain_b_i;
        end
      if( lock_rise )
        case( ctrl_i.man_sel )
          2'd0:    man_r <= ctrl_i.man_coef;
          2'd1:    man_g <= ctrl_i.man_coef;
          2'd2:    man_b <= ctrl_i.man_coef;
          default:; // sel 3 loads nothing.
        endcase
    end

always_comb
  case( ctrl_i.mode )
    MODE_MANUAL:
      begin
        gain_r_o = man_r;
        gain_g_o = man_g;
        gain_b_o = man_b;
      end
    MODE_AUTO:
      begin
        gain_r_o = auto_r;
        gain_g_o = COEF_ONE; // green is the reference.
        gain_b_o = auto_b;
      end
    default:
      begin
        gain_r_o = COEF_ONE;
        gain_g_o = COEF_ONE;
        gain_b_o = COEF_ONE;
      end
  endcase

endmodule

/* logic/wb_ctrl_if.sv */
interface wb_ctrl_if;

  import wb_pkg::*;

  logic [MODE_W-1:0] mode;
  logic              cal_stb;  // one cycle pulse.
  logic [1:0]        man_sel;
  logic [COEF_W-1:0] man_coef;
  logic              man_lock;

  modport master (output mode, cal_stb, man_sel, man_coef, man_lock);
  modport slave  (input  mode, cal_stb, man_sel, man_coef, man_lock);

endinterface

/* logic/wb_gain_estimator.sv */
module wb_gain_estimator (
  input                              clk_i,
  input                              rst_i,
  wb_ctrl_if.slave                   ctrl_i,
  input        [3*wb_pkg::PIX_W-1:0] pix_i,
  input                              pix_valid_i,
  output logic [wb_pkg::COEF_W-1:0]  auto_gain_r_o,
  output logic [wb_pkg::COEF_W-1:0]  auto_gain_b_o,
  output logic                       cal_done_o
);

import wb_pkg::*;

localparam int DVD_W  = SUM_W + COEF_FRAC;
localparam int CNT_W  = $clog2( CAL_PIX_CNT );
localparam int STEP_W = $clog2( DIV_STEPS );

typedef enum logic [1:0] { ST_IDLE, ST_ACC, ST_DIV } state_t;

state_t            state;
logic [CNT_W-1:0]  pix_cnt;
logic [STEP_W-1:0] step_cnt;
logic              div_blue;
logic              last_pix;
logic              last_step;
logic [SUM_W-1:0]  sum_r;
logic [SUM_W-1:0]  sum_g;
logic [SUM_W-1:0]  sum_b;
logic [SUM_W-1:0]  sum_r_nxt;
logic [SUM_W-1:0]  sum_g_nxt;
logic [SUM_W-1:0]  sum_b_nxt;
logic [SUM_W-1:0]  rem;
logic [SUM_W-1:0]  rem_nxt;
logic [DVD_W-1:0]  dvd;
logic [DVD_W-1:0]  quo;
logic [SUM_W-1:0]  divisor;
logic [SUM_W:0]    trial;
logic              q_bit;
logic [COEF_W-1:0] gain;

// pixel is {r, g, b}.
assign sum_r_nxt = sum_r + SUM_W'( pix_i[2*PIX_W +: PIX_W] );
assign sum_g_nxt = sum_g + SUM_W'( pix_i[PIX_W +: PIX_W] );
assign sum_b_nxt = sum_b + SUM_W'( pix_i[0 +: PIX_W] );

assign last_pix  = ( state == ST_ACC ) && pix_valid_i && ( pix_cnt == CNT_W'( CAL_PIX_CNT - 1 ) );
assign last_step = ( state == ST_DIV ) && ( step_cnt == STEP_W'( DIV_STEPS - 1 ) );

// restoring step; quotient bits shift into dvd from the bottom.
assign divisor = div_blue ? sum_b : sum_r;
assign trial   = { rem, dvd[DVD_W-1] };
assign q_bit   = trial >= { 1'b0, divisor };
assign rem_nxt = q_bit ? SUM_W'( trial - { 1'b0, divisor } ) : trial[SUM_W-1:0];
assign quo     = { dvd[DVD_W-2:0], q_bit };

always_comb
  if( divisor == '0 )
    gain = COEF_ONE;
  else
    if( |quo[DVD_W-1:COEF_W] )
      gain = '1; // clip to 65535.
    else
      gain = quo[COEF_W-1:0];

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    begin
      state         <= ST_IDLE;
      pix_cnt       <= '0;
      step_cnt      <= '0;
      div_blue      <= 1'b0;
      cal_done_o    <= 1'b0;
      auto_gain_r_o <= COEF_ONE;
      auto_gain_b_o <= COEF_ONE;
    end
  else
    begin
      cal_done_o <= 1'b0;
      if( ctrl_i.cal_stb )
        begin
          state   <= ST_ACC; // also restarts a busy calibration.
          pix_cnt <= '0;
        end
      else
        case( state )
          ST_ACC:
            if( pix_valid_i )
              begin
                pix_cnt <= pix_cnt + 1'b1;
                if( last_pix )
                  begin
                    state    <= ST_DIV;
                    step_cnt <= '0;
                    div_blue <= 1'b0;
                  end
              end
          ST_DIV:
            if( last_step )
              begin
                step_cnt <= '0;
                div_blue <= 1'b1;
                if( div_blue )
                  begin
                    auto_gain_b_o <= gain;
                    cal_done_o    <= 1'b1;
                    state         <= ST_IDLE;
                  end
                else
                  auto_gain_r_o <= gain;
              end
            else
              step_cnt <= step_cnt + 1'b1;
          default:;
        endcase
    end

always_ff @( posedge clk_i )
  if( ctrl_i.cal_stb )
    begin
      sum_r <= '0;
      sum_g <= '0;
      sum_b <= '0;
    end
  else
    if( ( state == ST_ACC ) && pix_valid_i )
      begin
        sum_r <= sum_r_nxt;
        sum_g <= sum_g_nxt;
        sum_b <= sum_b_nxt;
        if( last_pix )
          begin
            rem <= '0;
            dvd <= { sum_g_nxt, { COEF_FRAC{ 1'b0 } } };
          end
      end
    else
      if( state == ST_DIV )
        if( last_step )
          begin
            rem <= '0; // reload for the blue pass.
            dvd <= { sum_g, { COEF_FRAC{ 1'b0 } } };
          end
        else
          begin
            rem <= rem_nxt;
            dvd <= quo;
          end

endmodule

/* logic/wb_pixel_scaler.sv */
module wb_pixel_scaler (
  input                              clk_i,
  input                              rst_i,
  input        [3*wb_pkg::PIX_W-1:0] pix_i,
  input                              pix_valid_i,
  input        [wb_pkg::COEF_W-1:0]  gain_r_i,
  input        [wb_pkg::COEF_W-1:0]  gain_g_i,
  input        [wb_pkg::COEF_W-1:0]  gain_b_i,
  output logic [3*wb_pkg::PIX_W-1:0] pix_o,
  output logic                       pix_valid_o
);

import wb_pkg::*;

localparam int PROD_W = PIX_W + COEF_W;
localparam int RND_W  = PROD_W - COEF_FRAC;

logic [COEF_W-1:0]  gain [3];
logic [3*PIX_W-1:0] scaled;

assign gain[2] = gain_r_i;
assign gain[1] = gain_g_i;
assign gain[0] = gain_b_i;

for( genvar c = 0; c < 3; c++ )
  begin : g_chan
    logic [PROD_W-1:0] prod;
    logic [PROD_W-1:0] prod_rnd;
    logic [RND_W-1:0]  rnd;

    assign prod     = pix_i[c*PIX_W +: PIX_W] * gain[c];
    assign prod_rnd = prod + PROD_W'( 1 << ( COEF_FRAC - 1 ) ); // round half up.
    assign rnd      = prod_rnd[PROD_W-1:COEF_FRAC];

    assign scaled[c*PIX_W +: PIX_W] = ( |rnd[RND_W-1:PIX_W] ) ? '1 : rnd[PIX_W-1:0];
  end

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    pix_valid_o <= 1'b0;
  else
    pix_valid_o <= pix_valid_i;

always_ff @( posedge clk_i )
  pix_o <= scaled;

endmodule

/* logic/wb_pkg.sv */
package wb_pkg;

  localparam int WB_MODE_CR     = 0;
  localparam int WB_CAL_STB_CR  = 1;
  localparam int WB_MAN_SEL_CR  = 2;
  localparam int WB_MAN_COEF_CR = 3;
  localparam int WB_MAN_LOCK_CR = 4;
  localparam int TOTAL_CSR_CNT  = 5;

  localparam int AXI_ADDR_W = 32;
  localparam int AXI_DATA_W = 32;

  localparam int               MODE_W      = 2;
  localparam logic [MODE_W-1:0] MODE_BYPASS = 2'd0;
  localparam logic [MODE_W-1:0] MODE_MANUAL = 2'd1;
  localparam logic [MODE_W-1:0] MODE_AUTO   = 2'd2;

  localparam int PIX_W = 8;

  // gains are unsigned q4.12.
  localparam int                COEF_W    = 16;
  localparam int                COEF_FRAC = 12;
  localparam logic [COEF_W-1:0] COEF_ONE  = 16'd4096;

  localparam int CAL_PIX_CNT = 64;
  localparam int SUM_W       = 14; // 64 * 255 fits.
  localparam int DIV_STEPS   = 26; // one step per dividend bit.

endpackage

/* logic/wb_top.sv */
module wb_top #(
  parameter logic [wb_pkg::AXI_ADDR_W-1:0] BASE_ADDR = '0
)(
  input                                clk_i,
  input                                rst_i,
  input  [wb_pkg::AXI_ADDR_W-1:0]      s_awaddr_i,
  input                                s_awvalid_i,
  output                               s_awready_o,
  input  [wb_pkg::AXI_DATA_W-1:0]      s_wdata_i,
  input  [wb_pkg::AXI_DATA_W/8-1:0]    s_wstrb_i,
  input                                s_wvalid_i,
  output                               s_wready_o,
  output                               s_bvalid_o,
  input                                s_bready_i,
  output [1:0]                         s_bresp_o,
  input  [wb_pkg::AXI_ADDR_W-1:0]      s_araddr_i,
  input                                s_arvalid_i,
  output                               s_arready_o,
  output [wb_pkg::AXI_DATA_W-1:0]      s_rdata_o,
  output                               s_rvalid_o,
  input                                s_rready_i,
  output [1:0]                         s_rresp_o,
  input  [3*wb_pkg::PIX_W-1:0]         pix_i,
  input                                pix_valid_i,
  output [3*wb_pkg::PIX_W-1:0]         pix_o,
  output                               pix_valid_o
);

import wb_pkg::*;

logic [COEF_W-1:0] auto_gain_r;
logic [COEF_W-1:0] auto_gain_b;
logic              cal_done;
logic [COEF_W-1:0] gain_r;
logic [COEF_W-1:0] gain_g;
logic [COEF_W-1:0] gain_b;

axi4_lite_if axi_if();
wb_ctrl_if   ctrl_if();

assign axi_if.awaddr  = s_awaddr_i;
assign axi_if.awvalid = s_awvalid_i;
assign axi_if.wdata   = s_wdata_i;
assign axi_if.wstrb   = s_wstrb_i;
assign axi_if.wvalid  = s_wvalid_i;
assign axi_if.bready  = s_bready_i;
assign axi_if.araddr  = s_araddr_i;
assign axi_if.arvalid = s_arvalid_i;
assign axi_if.rready  = s_rready_i;
assign s_awready_o    = axi_if.awready;
assign s_wready_o     = axi_if.wready;
assign s_bvalid_o     = axi_if.bvalid;
assign s_bresp_o      = axi_if.bresp;
assign s_arready_o    = axi_if.arready;
assign s_rdata_o      = axi_if.rdata;
assign s_rvalid_o     = axi_if.rvalid;
assign s_rresp_o      = axi_if.rresp;

white_balance_corrector_csr #(
  .BASE_ADDR ( BASE_ADDR )
) u_csr (
  .clk_i     ( clk_i     ),
  .rst_i     ( rst_i     ),
  .csr_i     ( axi_if    ),
  .wb_ctrl_o ( ctrl_if   )
);

wb_gain_estimator u_estimator (
  .clk_i         ( clk_i       ),
  .rst_i         ( rst_i       ),
  .ctrl_i        ( ctrl_if     ),
  .pix_i         ( pix_i       ),
  .pix_valid_i   ( pix_valid_i ),
  .auto_gain_r_o ( auto_gain_r ),
  .auto_gain_b_o ( auto_gain_b ),
  .cal_done_o    ( cal_done    )
);

wb_coef_bank u_bank (
  .clk_i         ( clk_i       ),
  .rst_i         ( rst_i       ),
  .ctrl_i        ( ctrl_if     ),
  .auto_gain_r_i ( auto_gain_r ),
  .auto_gain_b_i ( auto_gain_b ),
  .cal_done_i    ( cal_done    ),
  .gain_r_o      ( gain_r      ),
  .gain_g_o      ( gain_g      ),
  .gain_b_o      ( gain_b      )
);

wb_pixel_scaler u_scaler (
  .clk_i       ( clk_i       ),
  .rst_i       ( rst_i       ),
  .pix_i       ( pix_i       ),
  .pix_valid_i ( pix_valid_i ),
  .gain_r_i    ( gain_r      ),
  .gain_g_i    ( gain_g      ),
  .gain_b_i    ( gain_b      ),
  .pix_o       ( pix_o       ),
  .pix_valid_o ( pix_valid_o )
);

endmodule

/* logic/white_balance_corrector_csr.sv */
module white_balance_corrector_csr #(
  parameter logic [wb_pkg::AXI_ADDR_W-1:0] BASE_ADDR = '0
)(
  input              clk_i,
  input              rst_i,
  axi4_lite_if.slave csr_i,
  wb_ctrl_if.master  wb_ctrl_o
);

import wb_pkg::*;

localparam int IDX_W  = $clog2( TOTAL_CSR_CNT );
localparam int STRB_W = AXI_DATA_W / 8;

logic [AXI_ADDR_W-1:0] wr_offs;
logic [AXI_ADDR_W-1:0] rd_offs;
logic                  wr_addr_match;
logic                  rd_addr_match;
logic                  aw_hs;
logic                  w_hs;
logic                  ar_hs;
logic                  b_hs;
logic                  r_hs;
logic                  aw_done;
logic                  w_done;
logic                  wr_req;
logic [IDX_W-1:0]      wr_idx;
logic [IDX_W-1:0]      rd_idx;
logic [AXI_DATA_W-1:0] wdata_lock;
logic [STRB_W-1:0]     wstrb_lock;
logic [AXI_DATA_W-1:0] rd_word;

logic [MODE_W-1:0]     mode_cr;
logic                  cal_stb_cr;
logic                  cal_stb_d1;
logic [1:0]            man_sel_cr;
logic [AXI_DATA_W-1:0] man_coef_cr;
logic                  man_lock_cr;

assign wr_offs       = csr_i.awaddr - BASE_ADDR;
assign rd_offs       = csr_i.araddr - BASE_ADDR;
assign wr_addr_match = ( csr_i.awaddr >= BASE_ADDR ) && ( ( wr_offs >> 2 ) < TOTAL_CSR_CNT );
assign rd_addr_match = ( csr_i.araddr >= BASE_ADDR ) && ( ( rd_offs >> 2 ) < TOTAL_CSR_CNT );
assign rd_idx        = IDX_W'( rd_offs >> 2 );

// one write in flight; the phase already taken holds its ready low.
assign csr_i.awready = !aw_done && !csr_i.bvalid && wr_addr_match;
assign csr_i.wready  = !w_done && !csr_i.bvalid && !( csr_i.awvalid && !wr_addr_match );
assign csr_i.arready = 1'b1;
assign csr_i.bresp   = 2'b00;
assign csr_i.rresp   = 2'b00;

assign aw_hs  = csr_i.awvalid && csr_i.awready;
assign w_hs   = csr_i.wvalid && csr_i.wready;
assign ar_hs  = csr_i.arvalid && rd_addr_match && !csr_i.rvalid;
assign b_hs   = csr_i.bvalid && csr_i.bready;
assign r_hs   = csr_i.rvalid && csr_i.rready;
assign wr_req = aw_done && w_done;

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    begin
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end
  else
    if( wr_req )
      begin
        aw_done <= 1'b0;
        w_done  <= 1'b0;
      end
    else
      begin
        if( aw_hs )
          aw_done <= 1'b1;
        if( w_hs )
          w_done <= 1'b1;
      end

always_ff @( posedge clk_i )
  begin
    if( aw_hs )
      wr_idx <= IDX_W'( wr_offs >> 2 );
    if( w_hs )
      begin
        wdata_lock <= csr_i.wdata;
        wstrb_lock <= csr_i.wstrb;
      end
  end

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    begin
      mode_cr     <= MODE_AUTO;
      cal_stb_cr  <= 1'b0;
      man_sel_cr  <= 2'd0;
      man_coef_cr <= '0;
      man_lock_cr <= 1'b0;
    end
  else
    if( wr_req )
      case( wr_idx )
        WB_MODE_CR:
          if( wstrb_lock[0] )
            mode_cr <= wdata_lock[MODE_W-1:0];
        WB_CAL_STB_CR:
          if( wstrb_lock[0] )
            cal_stb_cr <= wdata_lock[0];
        WB_MAN_SEL_CR:
          if( wstrb_lock[0] )
            man_sel_cr <= wdata_lock[1:0];
        WB_MAN_COEF_CR:
          for( int i = 0; i < STRB_W; i++ )
            if( wstrb_lock[i] )
              man_coef_cr[i*8 +: 8] <= wdata_lock[i*8 +: 8];
        WB_MAN_LOCK_CR:
          if( wstrb_lock[0] )
            man_lock_cr <= wdata_lock[0];
        default:;
      endcase

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    csr_i.bvalid <= 1'b0;
  else
    if( wr_req )
      csr_i.bvalid <= 1'b1;
    else
      if( b_hs )
        csr_i.bvalid <= 1'b0;

always_comb
  case( rd_idx )
    WB_MODE_CR:     rd_word = AXI_DATA_W'( mode_cr );
    WB_CAL_STB_CR:  rd_word = AXI_DATA_W'( cal_stb_cr );
    WB_MAN_SEL_CR:  rd_word = AXI_DATA_W'( man_sel_cr );
    WB_MAN_COEF_CR: rd_word = man_coef_cr;
    WB_MAN_LOCK_CR: rd_word = AXI_DATA_W'( man_lock_cr );
    default:        rd_word = '0;
  endcase

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    csr_i.rvalid <= 1'b0;
  else
    if( ar_hs )
      csr_i.rvalid <= 1'b1;
    else
      if( r_hs )
        csr_i.rvalid <= 1'b0;

// held until the next accepted read.
always_ff @( posedge clk_i )
  if( ar_hs )
    csr_i.rdata <= rd_word;

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    cal_stb_d1 <= 1'b0;
  else
    cal_stb_d1 <= cal_stb_cr;

assign wb_ctrl_o.mode     = mode_cr;
assign wb_ctrl_o.cal_stb  = cal_stb_cr && !cal_stb_d1;
assign wb_ctrl_o.man_sel  = man_sel_cr;
assign wb_ctrl_o.man_coef = man_coef_cr[COEF_W-1:0];
assign wb_ctrl_o.man_lock = man_lock_cr;

endmodule

/* src.f */
logic/wb_pkg.sv
logic/axi4_lite_if.sv
logic/wb_ctrl_if.sv
logic/white_balance_corrector_csr.sv
logic/wb_gain_estimator.sv
logic/wb_coef_bank.sv
logic/wb_pixel_scaler.sv
logic/wb_top.sv
tests/wb_top_checker.sv
tests/tb_wb_top.sv

/* tests/tb_wb_top.sv */
module tb_wb_top;

import wb_pkg::*;

localparam int CLK_PERIOD    = 40;
localparam int RST_CYCLES    = 5;
localparam int T1_CYCLES     = 300;
localparam int T2_CYCLES     = 150;
localparam int T3_CYCLES     = 150;
localparam int T4_CYCLES     = 350;
localparam int T5_CYCLES     = 250;
localparam int RUN_CYCLES    = RST_CYCLES + T1_CYCLES + T2_CYCLES + T3_CYCLES + T4_CYCLES
                               + T5_CYCLES;
localparam int WATCHDOG_TIME = RUN_CYCLES * CLK_PERIOD * 6 / 5; // 20% margin.

logic                    clk_i;
logic                    rst_i;
logic [AXI_ADDR_W-1:0]   s_awaddr_i;
logic                    s_awvalid_i;
logic                    s_awready_o;
logic [AXI_DATA_W-1:0]   s_wdata_i;
logic [AXI_DATA_W/8-1:0] s_wstrb_i;
logic                    s_wvalid_i;
logic                    s_wready_o;
logic                    s_bvalid_o;
logic                    s_bready_i;
logic [1:0]              s_bresp_o;
logic [AXI_ADDR_W-1:0]   s_araddr_i;
logic                    s_arvalid_i;
logic                    s_arready_o;
logic [AXI_DATA_W-1:0]   s_rdata_o;
logic                    s_rvalid_o;
logic                    s_rready_i;
logic [1:0]              s_rresp_o;
logic [3*PIX_W-1:0]      pix_i;
logic                    pix_valid_i;
logic [3*PIX_W-1:0]      pix_o;
logic                    pix_valid_o;

logic [AXI_DATA_W-1:0] shadow [TOTAL_CSR_CNT]; // register model.
logic [COEF_W-1:0]     man_gain_r;             // manual gain mirror for the checker.
logic [COEF_W-1:0]     man_gain_g;
logic [COEF_W-1:0]     man_gain_b;
string                 reg_name [TOTAL_CSR_CNT] = '{ "mode", "cal_stb", "man_sel",
                                                     "man_coef", "man_lock" };
int                    err_cnt;
int                    test_cnt;
int                    test_fail_cnt;
int                    errs_at_start;
string                 test_name;

wb_top DUT (
  .clk_i       ( clk_i       ),
  .rst_i       ( rst_i       ),
  .s_awaddr_i  ( s_awaddr_i  ),
  .s_awvalid_i ( s_awvalid_i ),
  .s_awready_o ( s_awready_o ),
  .s_wdata_i   ( s_wdata_i   ),
  .s_wstrb_i   ( s_wstrb_i   ),
  .s_wvalid_i  ( s_wvalid_i  ),
  .s_wready_o  ( s_wready_o  ),
  .s_bvalid_o  ( s_bvalid_o  ),
  .s_bready_i  ( s_bready_i  ),
  .s_bresp_o   ( s_bresp_o   ),
  .s_araddr_i  ( s_araddr_i  ),
  .s_arvalid_i ( s_arvalid_i ),
  .s_arready_o ( s_arready_o ),
  .s_rdata_o   ( s_rdata_o   ),
  .s_rvalid_o  ( s_rvalid_o  ),
  .s_rready_i  ( s_rready_i  ),
  .s_rresp_o   ( s_rresp_o   ),
  .pix_i       ( pix_i       ),
  .pix_valid_i ( pix_valid_i ),
  .pix_o       ( pix_o       ),
  .pix_valid_o ( pix_valid_o )
);

bind wb_top wb_top_checker u_checker (
  .clk_i           ( clk_i        ),
  .rst_i           ( rst_i        ),
  .pix_i           ( pix_i        ),
  .pix_valid_i     ( pix_valid_i  ),
  .pix_out_i       ( pix_o        ),
  .pix_out_valid_i ( pix_valid_o  ),
  .mode_i          ( ctrl_if.mode ),
  .bvalid_i        ( s_bvalid_o   ),
  .bready_i        ( s_bready_i   ),
  .rvalid_i        ( s_rvalid_o   ),
  .rready_i        ( s_rready_i   ),
  .rdata_i         ( s_rdata_o    )
);

initial
  begin
    clk_i = 1'b0;
    forever
      #( CLK_PERIOD / 2 ) clk_i = ~clk_i;
  end

initial
  begin
    #( WATCHDOG_TIME );
    $display( "watchdog expired at %0t, a test did not complete", $time );
    $display( "Simulation FAILED" );
    $finish;
  end

function automatic int total_errors();
  return err_cnt + int'( DUT.u_checker.fail_cnt );
endfunction

function automatic logic [PIX_W-1:0] scale_chan(input logic [PIX_W-1:0] p,
                                                input logic [COEF_W-1:0] g);
  logic [31:0] v;
  v = ( 32'( p ) * 32'( g ) + 32'd2048 ) >> 12;
  return ( v > 32'd255 ) ? 8'd255 : v[PIX_W-1:0];
endfunction

// bits of a register that a write can change.
function automatic logic [31:0] field_mask(input int idx);
  case( idx )
    WB_MODE_CR:     return 32'h3;
    WB_MAN_SEL_CR:  return 32'h3;
    WB_MAN_COEF_CR: return 32'hffff_ffff;
    default:        return 32'h1;
  endcase
endfunction

task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
  if( act !== exp )
    begin
      err_cnt++;
      $display( "FAILED t=%0t %s expected %h actual %h", $time, name, exp, act );
    end
endtask

task automatic start_test(input string name);
  test_name     = name;
  errs_at_start = total_errors();
endtask

task automatic finish_test();
  int errs;
  errs = total_errors() - errs_at_start;
  test_cnt++;
  if( errs == 0 )
    $display( "test %0d %s: ok", test_cnt, test_name );
  else
    begin
      test_fail_cnt++;
      $display( "test %0d %s: %0d errors", test_cnt, test_name, errs );
    end
endtask

// tasks start and end 1 time unit after a rising edge; handshakes sample at the falling edge.
task automatic write_reg(input int idx, input logic [31:0] data, input logic [3:0] strb,
                         input int aw_lag, input int b_lag);
  logic        aw_ok;
  logic        w_ok;
  logic        b_ok;
  logic        aw_seen;
  logic        w_seen;
  logic        b_seen;
  logic [1:0]  resp;
  logic [31:0] m;
  logic        old_lock;
  int          cyc;
  s_awaddr_i  = 32'( idx * 4 );
  s_awvalid_i = ( aw_lag == 0 );
  s_wdata_i   = data;
  s_wstrb_i   = strb;
  s_wvalid_i  = 1'b1;
  aw_seen     = 1'b0;
  w_seen      = 1'b0;
  cyc         = 0;
  while( !( aw_seen && w_seen ) )
    begin
      @( negedge clk_i );
      aw_ok = s_awvalid_i && s_awready_o;
      w_ok  = s_wvalid_i && s_wready_o;
      @( posedge clk_i );
      #1;
      cyc++;
      if( aw_ok )
        begin
          aw_seen     = 1'b1;
          s_awvalid_i = 1'b0;
        end
      if( w_ok )
        begin
          w_seen     = 1'b1;
          s_wvalid_i = 1'b0;
        end
      if( !aw_seen && cyc >= aw_lag )
        s_awvalid_i = 1'b1;
    end
  cyc        = 0;
  b_ok       = 1'b0;
  resp       = '0;
  s_bready_i = ( b_lag == 0 );
  while( !b_ok )
    begin
      @( negedge clk_i );
      b_seen = s_bvalid_o;
      b_ok   = s_bvalid_o && s_bready_i;
      resp   = s_bresp_o;
      @( posedge clk_i );
      #1;
      if( b_seen )
        cyc++;
      if( cyc >= b_lag )
        s_bready_i = 1'b1;
    end
  s_bready_i = 1'b0;
  check_value( "s_bresp_o", 32'd0, 32'( resp ) );
  m        = { { 8{ strb[3] } }, { 8{ strb[2] } }, { 8{ strb[1] } }, { 8{ strb[0] } } };
  m        = m & field_mask( idx );
  old_lock = shadow[WB_MAN_LOCK_CR][0];
  shadow[idx] = ( shadow[idx] & ~m ) | ( data & m );
  if( idx == WB_MAN_LOCK_CR && !old_lock && shadow[idx][0] )
    case( shadow[WB_MAN_SEL_CR][1:0] )
      2'd0:    man_gain_r = shadow[WB_MAN_COEF_CR][15:0];
      2'd1:    man_gain_g = shadow[WB_MAN_COEF_CR][15:0];
      2'd2:    man_gain_b = shadow[WB_MAN_COEF_CR][15:0];
      default:;
    endcase
endtask

task automatic read_check(input int idx, input int r_lag);
  logic        ar_ok;
  logic        r_ok;
  logic [31:0] data;
  logic [1:0]  resp;
  int          cyc;
  s_araddr_i  = 32'( idx * 4 );
  s_arvalid_i = 1'b1;
  ar_ok       = 1'b0;
  while( !ar_ok )
    begin
      @( negedge clk_i );
      ar_ok = s_arready_o;
      @( posedge clk_i );
      #1;
    end
  s_arvalid_i = 1'b0;
  cyc         = 0;
  r_ok        = 1'b0;
  resp        = '0;
  s_rready_i  = ( r_lag == 0 );
  while( !r_ok )
    begin
      @( negedge clk_i );
      r_ok = s_rvalid_o && s_rready_i;
      data = s_rdata_o;
      resp = s_rresp_o;
      if( s_rvalid_o )
        cyc++;
      @( posedge clk_i );
      #1;
      if( cyc >= r_lag )
        s_rready_i = 1'b1;
    end
  s_rready_i = 1'b0;
  check_value( "s_rresp_o", 32'd0, 32'( resp ) );
  check_value( { "rdata(", reg_name[idx], ")" }, shadow[idx], data );
endtask

task automatic read_all();
  for( int i = 0; i < TOTAL_CSR_CNT; i++ )
    read_check( i, 0 );
endtask

task automatic try_out_of_range_write(input logic [31:0] addr, input logic [31:0] data);
  s_awaddr_i  = addr;
  s_awvalid_i = 1'b1;
  s_wdata_i   = data;
  s_wstrb_i   = '1;
  s_wvalid_i  = 1'b1;
  repeat( 4 )
    begin
      @( negedge clk_i );
      if( s_awready_o || s_wready_o || s_bvalid_o )
        begin
          err_cnt++;
          $display( "write to out-of-range address %h was accepted at %0t", addr, $time );
        end
      @( posedge clk_i );
      #1;
    end
  s_awvalid_i = 1'b0;
  s_wvalid_i  = 1'b0;
endtask

task automatic send_pixels(input int n, input logic [3*PIX_W-1:0] value, input bit random_pix);
  for( int i = 0; i < n; i++ )
    begin
      pix_i       = random_pix ? 24'( $urandom ) : value;
      pix_valid_i = 1'b1;
      @( posedge clk_i );
      #1;
    end
  pix_valid_i = 1'b0;
  repeat( 2 )
    @( posedge clk_i );
  #1;
endtask

initial
  begin
    logic [COEF_W-1:0]  gain_exp_r;
    logic [COEF_W-1:0]  gain_exp_b;
    logic [3*PIX_W-1:0] pix_exp;
    void'( $urandom( 32'h8e42 ) );
    rst_i       = 1'b1;
    s_awaddr_i  = '0;
    s_awvalid_i = 1'b0;
    s_wdata_i   = '0;
    s_wstrb_i   = '0;
    s_wvalid_i  = 1'b0;
    s_bready_i  = 1'b0;
    s_araddr_i  = '0;
    s_arvalid_i = 1'b0;
    s_rready_i  = 1'b0;
    pix_i       = '0;
    pix_valid_i = 1'b0;
    shadow      = '{ 32'd2, 32'd0, 32'd0, 32'd0, 32'd0 };
    man_gain_r  = COEF_ONE;
    man_gain_g  = COEF_ONE;
    man_gain_b  = COEF_ONE;
    err_cnt       = 0;
    test_cnt      = 0;
    test_fail_cnt = 0;
    repeat( RST_CYCLES )
      @( posedge clk_i );
    #1;
    rst_i = 1'b0;

    start_test( "reset values and readback" );
    read_all();
    write_reg( WB_MAN_COEF_CR, 32'ha5a5_a5a5, 4'b0101, 0, 0 );
    read_check( WB_MAN_COEF_CR, 0 );
    write_reg( WB_MAN_COEF_CR, 32'h1234_5678, 4'b1010, 0, 0 );
    read_check( WB_MAN_COEF_CR, 0 );
    try_out_of_range_write( 32'h40, 32'hffff_ffff );
    read_all();
    finish_test();

    start_test( "axi response rules" );
    write_reg( WB_MAN_SEL_CR, 32'd1, 4'hf, 0, 3 + int'( $urandom % 6 ) );
    read_check( WB_MAN_SEL_CR, 3 + int'( $urandom % 6 ) );
    write_reg( WB_MAN_SEL_CR, 32'd2, 4'hf, 3, 0 ); // data phase first.
    read_check( WB_MAN_SEL_CR, 2 );
    finish_test();

    start_test( "bypass mode" );
    write_reg( WB_MODE_CR, 32'( MODE_BYPASS ), 4'hf, 0, 0 );
    read_check( WB_MODE_CR, 0 );
    send_pixels( 48, '0, 1'b1 );
    finish_test();

    start_test( "manual gains" );
    for( int c = 0; c < 3; c++ )
      begin
        write_reg( WB_MAN_SEL_CR, 32'( c ), 4'hf, 0, 0 );
        write_reg( WB_MAN_COEF_CR, ( c == 0 ) ? 32'd8192 : ( c == 1 ) ? 32'd2048 : 32'd6144,
                   4'hf, 0, 0 );
        write_reg( WB_MAN_LOCK_CR, 32'd1, 4'hf, 0, 0 );
        write_reg( WB_MAN_LOCK_CR, 32'd0, 4'hf, 0, 0 );
      end
    write_reg( WB_MODE_CR, 32'( MODE_MANUAL ), 4'hf, 0, 0 );
    send_pixels( 64, '0, 1'b1 );
    finish_test();

    start_test( "automatic calibration" );
    write_reg( WB_MODE_CR, 32'( MODE_AUTO ), 4'hf, 0, 0 );
    write_reg( WB_CAL_STB_CR, 32'd1, 4'hf, 0, 0 );
    send_pixels( CAL_PIX_CNT, { 8'd64, 8'd128, 8'd32 }, 1'b0 );
    repeat( 2 * DIV_STEPS + 1 + 8 )
      @( posedge clk_i );
    #1;
    gain_exp_r = COEF_W'( ( CAL_PIX_CNT * 128 * 4096 ) / ( CAL_PIX_CNT * 64 ) );
    gain_exp_b = COEF_W'( ( CAL_PIX_CNT * 128 * 4096 ) / ( CAL_PIX_CNT * 32 ) );
    pix_exp    = { scale_chan( 8'd50, gain_exp_r ), scale_chan( 8'd50, COEF_ONE ),
                   scale_chan( 8'd50, gain_exp_b ) };
    pix_i       = { 8'd50, 8'd50, 8'd50 };
    pix_valid_i = 1'b1;
    @( posedge clk_i );
    #1;
    pix_valid_i = 1'b0;
    @( negedge clk_i );
    check_value( "pix_valid_o", 32'd1, 32'( pix_valid_o ) );
    check_value( "pix_o", 32'( pix_exp ), 32'( pix_o ) );
    @( posedge clk_i );
    #1;
    finish_test();

    $display( "tests %0d, failed %0d, errors %0d", test_cnt, test_fail_cnt, total_errors() );
    if( total_errors() == 0 )
      $display( "Simulation PASSED" );
    else
      $display( "Simulation FAILED" );
    $finish;
  end

endmodule

/* tests/wb_top_checker.sv */
module wb_top_checker (
  input                             clk_i,
  input                             rst_i,
  input [3*wb_pkg::PIX_W-1:0]       pix_i,
  input                             pix_valid_i,
  input [3*wb_pkg::PIX_W-1:0]       pix_out_i,
  input                             pix_out_valid_i,
  input [wb_pkg::MODE_W-1:0]        mode_i,
  input                             bvalid_i,
  input                             bready_i,
  input                             rvalid_i,
  input                             rready_i,
  input [wb_pkg::AXI_DATA_W-1:0]    rdata_i
);

import wb_pkg::*;

int unsigned fail_cnt = 0;

// round half up, then clip at 255.
function automatic logic [PIX_W-1:0] scale_chan(input logic [PIX_W-1:0] p,
                                                input logic [COEF_W-1:0] g);
  logic [31:0] v;
  v = ( 32'( p ) * 32'( g ) + 32'd2048 ) >> 12;
  return ( v > 32'd255 ) ? 8'd255 : v[PIX_W-1:0];
endfunction

function automatic logic [3*PIX_W-1:0] scale_pixel(input logic [3*PIX_W-1:0] p,
                                                   input logic [COEF_W-1:0] gr,
                                                   input logic [COEF_W-1:0] gg,
                                                   input logic [COEF_W-1:0] gb);
  return { scale_chan( p[23:16], gr ), scale_chan( p[15:8], gg ), scale_chan( p[7:0], gb ) };
endfunction

a_valid_delay: assert property ( @( posedge clk_i ) disable iff ( rst_i )
  pix_out_valid_i == $past( pix_valid_i ) )
  else
    begin
      fail_cnt++;
      $error( "pix_valid_o does not follow pix_valid_i by one cycle" );
    end

a_bypass: assert property ( @( posedge clk_i ) disable iff ( rst_i )
  $past( pix_valid_i ) && ( $past( mode_i ) == MODE_BYPASS ) |-> pix_out_i == $past( pix_i ) )
  else
    begin
      fail_cnt++;
      $error( "bypass pixel differs from its input" );
    end

// gains come from the testbench's mirror of the manual set.
a_manual: assert property ( @( posedge clk_i ) disable iff ( rst_i )
  $past( pix_valid_i ) && ( $past( mode_i ) == MODE_MANUAL ) |->
    pix_out_i == scale_pixel( $past( pix_i ), $past( tb_wb_top.man_gain_r ),
                              $past( tb_wb_top.man_gain_g ), $past( tb_wb_top.man_gain_b ) ) )
  else
    begin
      fail_cnt++;
      $error( "manual mode pixel does not match the scaling rule" );
    end

a_bvalid_hold: assert property ( @( posedge clk_i ) disable iff ( rst_i )
  bvalid_i && !bready_i |=> bvalid_i )
  else
    begin
      fail_cnt++;
      $error( "bvalid dropped before bready" );
    end

a_rvalid_hold: assert property ( @( posedge clk_i ) disable iff ( rst_i )
  rvalid_i && !rready_i |=> rvalid_i && $stable( rdata_i ) )
  else
    begin
      fail_cnt++;
      $error( "rvalid or rdata changed before rready" );
    end

endmodule
